// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/count_lead_zero.sv
`timescale 1ns/1ns

module count_lead_zero import cpu_pkg::*; (
	input  uint32_t val,
	output uint32_t count
);

logic found;  // A set bit was already seen above

// Priority search where the first set bit from the top wins
always_comb begin
	count = 32'd32;  // All zero word
	found = 1'b0;
	for (int i = 31; i >= 0; i--) begin
		if (!found && val[i]) begin
			count = 32'(31 - i);
			found = 1'b1;
		end
	end
end

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

localparam int LANES = 2;  // Issue slots per bundle

typedef logic [31:0] uint32_t;   // Data word, instruction word, pc
typedef logic [4:0]  reg_addr_t; // GPR number
typedef logic [4:0]  shamt_t;    // Shift amount

localparam reg_addr_t LINK_REG = 5'd31;  // $ra

// Major opcodes in instr[31:26]
localparam logic [5:0] OPC_SPECIAL  = 6'b000000;
localparam logic [5:0] OPC_REGIMM   = 6'b000001;
localparam logic [5:0] OPC_JAL      = 6'b000011;
localparam logic [5:0] OPC_LUI      = 6'b001111;
localparam logic [5:0] OPC_SPECIAL2 = 6'b011100;

// SPECIAL function codes in instr[5:0]
localparam logic [5:0] FN_SLL  = 6'b000000;
localparam logic [5:0] FN_SRL  = 6'b000010;
localparam logic [5:0] FN_SRA  = 6'b000011;
localparam logic [5:0] FN_SLLV = 6'b000100;
localparam logic [5:0] FN_SRLV = 6'b000110;
localparam logic [5:0] FN_SRAV = 6'b000111;
localparam logic [5:0] FN_JALR = 6'b001001;
localparam logic [5:0] FN_MOVZ = 6'b001010;
localparam logic [5:0] FN_MOVN = 6'b001011;
localparam logic [5:0] FN_ADD  = 6'b100000;
localparam logic [5:0] FN_ADDU = 6'b100001;
localparam logic [5:0] FN_SUB  = 6'b100010;
localparam logic [5:0] FN_SUBU = 6'b100011;
localparam logic [5:0] FN_AND  = 6'b100100;
localparam logic [5:0] FN_OR   = 6'b100101;
localparam logic [5:0] FN_XOR  = 6'b100110;
localparam logic [5:0] FN_NOR  = 6'b100111;
localparam logic [5:0] FN_SLT  = 6'b101010;
localparam logic [5:0] FN_SLTU = 6'b101011;

// SPECIAL2 function codes
localparam logic [5:0] FN_CLZ  = 6'b100000;
localparam logic [5:0] FN_CLO  = 6'b100001;

// REGIMM rt codes in instr[20:16]
localparam logic [4:0] RT_BLTZAL = 5'b10000;
localparam logic [4:0] RT_BGEZAL = 5'b10001;

typedef enum logic [4:0] {
	OP_NOP,    // Unsupported or unknown encoding
	OP_LUI,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_NOR,
	OP_ADD,
	OP_ADDU,
	OP_SUB,
	OP_SUBU,
	OP_CLZ,
	OP_CLO,
	OP_MOVZ,
	OP_MOVN,
	OP_JAL,
	OP_JALR,
	OP_BLTZAL,
	OP_BGEZAL,
	OP_SLL,
	OP_SLLV,
	OP_SRL,
	OP_SRLV,
	OP_SRA,
	OP_SRAV,
	OP_SLT,
	OP_SLTU
} op_t;

endpackage

// File: logic/exec_cluster.sv
`timescale 1ns/1ns

module exec_cluster import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      flush,

	input  logic      issue_valid,
	input  uint32_t   issue_instr [LANES],
	input  uint32_t   issue_pc    [LANES],
	input  uint32_t   issue_reg1  [LANES],
	input  uint32_t   issue_reg2  [LANES],

	output logic      wb_valid    [LANES],
	output reg_addr_t wb_rd       [LANES],
	output uint32_t   wb_value    [LANES]
);

logic      dec_valid;
op_t       dec_op     [LANES];
reg_addr_t dec_rd     [LANES];
uint32_t   dec_instr  [LANES];
uint32_t   dec_pc     [LANES];
uint32_t   dec_reg1   [LANES];
uint32_t   dec_reg2   [LANES];

reg_addr_t lane_rd    [LANES];
uint32_t   lane_value [LANES];

issue_decode u_decode (
	.clk         (clk),
	.reset       (reset),
	.flush       (flush),
	.issue_valid (issue_valid),
	.issue_instr (issue_instr),
	.issue_pc    (issue_pc),
	.issue_reg1  (issue_reg1),
	.issue_reg2  (issue_reg2),
	.dec_valid   (dec_valid),
	.dec_op      (dec_op),
	.dec_rd      (dec_rd),
	.dec_instr   (dec_instr),
	.dec_pc      (dec_pc),
	.dec_reg1    (dec_reg1),
	.dec_reg2    (dec_reg2)
);

for (genvar i = 0; i < LANES; i++) begin : g_lane
	instr_exec u_lane (
		.op           (dec_op[i]),
		.rd           (dec_rd[i]),
		.instr        (dec_instr[i]),
		.pc           (dec_pc[i]),
		.reg1         (dec_reg1[i]),
		.reg2         (dec_reg2[i]),
		.result_rd    (lane_rd[i]),
		.result_value (lane_value[i])
	);
end

exec_retire u_retire (
	.clk        (clk),
	.reset      (reset),
	.flush      (flush),
	.dec_valid  (dec_valid),
	.lane_rd    (lane_rd),
	.lane_value (lane_value),
	.wb_valid   (wb_valid),
	.wb_rd      (wb_rd),
	.wb_value   (wb_value)
);

endmodule

// File: logic/exec_retire.sv
`timescale 1ns/1ns

module exec_retire import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      flush,

	input  logic      dec_valid,
	input  reg_addr_t lane_rd    [LANES],
	input  uint32_t   lane_value [LANES],

	output logic      wb_valid   [LANES],
	output reg_addr_t wb_rd      [LANES],
	output uint32_t   wb_value   [LANES]
);

// Every slot of a bundle retires together
always_ff @(posedge clk) begin
	for (int i = 0; i < LANES; i++) begin
		if (reset || flush) begin
			wb_valid[i] <= 1'b0;
		end else begin
			wb_valid[i] <= dec_valid;
		end
	end
end

// Write-back payload where rd of zero means no write
always_ff @(posedge clk) begin
	for (int i = 0; i < LANES; i++) begin
		wb_rd[i]    <= lane_rd[i];
		wb_value[i] <= lane_value[i];
	end
end

endmodule

// File: logic/instr_exec.sv
`timescale 1ns/1ns

module instr_exec import cpu_pkg::*; (
	input  op_t       op,
	input  reg_addr_t rd,
	input  uint32_t   instr,
	input  uint32_t   pc,
	input  uint32_t   reg1,
	input  uint32_t   reg2,

	output reg_addr_t result_rd,
	output uint32_t   result_value
);

uint32_t add_u, sub_u;
uint32_t reg1_inv;
uint32_t clz_cnt, clo_cnt;
shamt_t  shift_amt;
logic    signed_lt, unsigned_lt;

// Wrapping arithmetic without overflow trap
assign add_u = reg1 + reg2;
assign sub_u = reg1 - reg2;

// Signs differ means reg1 is less exactly when it is negative
assign signed_lt   = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
assign unsigned_lt = (reg1 < reg2);

assign reg1_inv = ~reg1;  // CLO is CLZ of the inverted word

count_lead_zero u_clz (
	.val   (reg1),
	.count (clz_cnt)
);

count_lead_zero u_clo (
	.val   (reg1_inv),
	.count (clo_cnt)
);

// Variable forms take rs[4:0] and fixed forms take sa
always_comb begin
	case (op)
		OP_SLLV, OP_SRLV, OP_SRAV: shift_amt = reg1[4:0];
		default:                   shift_amt = instr[10:6];
	endcase
end

// Failed conditional move writes nothing
always_comb begin
	result_rd = rd;
	if ((op == OP_MOVZ && reg2 != '0) || (op == OP_MOVN && reg2 == '0)) begin
		result_rd = '0;
	end
end

always_comb begin
	case (op)
		OP_LUI: result_value = {instr[15:0], 16'b0};
		OP_AND: result_value = reg1 & reg2;
		OP_OR:  result_value = reg1 | reg2;
		OP_XOR: result_value = reg1 ^ reg2;
		OP_NOR: result_value = ~(reg1 | reg2);

		OP_ADD, OP_ADDU: result_value = add_u;
		OP_SUB, OP_SUBU: result_value = sub_u;

		OP_CLZ: result_value = clz_cnt;
		OP_CLO: result_value = clo_cnt;

		OP_MOVZ, OP_MOVN: result_value = reg1;

		// Return address skips the delay slot
		OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: result_value = pc + 32'd8;

		OP_SLL, OP_SLLV: result_value = reg2 << shift_amt;
		OP_SRL, OP_SRLV: result_value = reg2 >> shift_amt;
		OP_SRA, OP_SRAV: result_value = uint32_t'($signed(reg2) >>> shift_amt);

		OP_SLT:  result_value = {31'b0, signed_lt};
		OP_SLTU: result_value = {31'b0, unsigned_lt};

		OP_NOP:  result_value = '0;
		default: result_value = '0;
	endcase
end

endmodule

// File: logic/issue_decode.sv
`timescale 1ns/1ns

module issue_decode import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      flush,

	input  logic      issue_valid,
	input  uint32_t   issue_instr [LANES],
	input  uint32_t   issue_pc    [LANES],
	input  uint32_t   issue_reg1  [LANES],
	input  uint32_t   issue_reg2  [LANES],

	output logic      dec_valid,
	output op_t       dec_op      [LANES],
	output reg_addr_t dec_rd      [LANES],
	output uint32_t   dec_instr   [LANES],
	output uint32_t   dec_pc      [LANES],
	output uint32_t   dec_reg1    [LANES],
	output uint32_t   dec_reg2    [LANES]
);

op_t       op_next [LANES];
reg_addr_t rd_next [LANES];

function automatic op_t decode_op(input uint32_t instr);
	op_t op;
	op = OP_NOP;
	case (instr[31:26])
		OPC_SPECIAL: begin
			case (instr[5:0])
				FN_SLL:  op = OP_SLL;
				FN_SRL:  op = OP_SRL;
				FN_SRA:  op = OP_SRA;
				FN_SLLV: op = OP_SLLV;
				FN_SRLV: op = OP_SRLV;
				FN_SRAV: op = OP_SRAV;
				FN_JALR: op = OP_JALR;
				FN_MOVZ: op = OP_MOVZ;
				FN_MOVN: op = OP_MOVN;
				FN_ADD:  op = OP_ADD;
				FN_ADDU: op = OP_ADDU;
				FN_SUB:  op = OP_SUB;
				FN_SUBU: op = OP_SUBU;
				FN_AND:  op = OP_AND;
				FN_OR:   op = OP_OR;
				FN_XOR:  op = OP_XOR;
				FN_NOR:  op = OP_NOR;
				FN_SLT:  op = OP_SLT;
				FN_SLTU: op = OP_SLTU;
				default: op = OP_NOP;
			endcase
		end
		OPC_SPECIAL2: begin
			case (instr[5:0])
				FN_CLZ:  op = OP_CLZ;
				FN_CLO:  op = OP_CLO;
				default: op = OP_NOP;
			endcase
		end
		OPC_REGIMM: begin
			case (instr[20:16])
				RT_BLTZAL: op = OP_BLTZAL;
				RT_BGEZAL: op = OP_BGEZAL;
				default:   op = OP_NOP;  // Plain branches write nothing
			endcase
		end
		OPC_LUI: op = OP_LUI;
		OPC_JAL: op = OP_JAL;
		default: op = OP_NOP;
	endcase
	return op;
endfunction

// Destination register for a decoded operation
function automatic reg_addr_t decode_rd(input uint32_t instr, input op_t op);
	reg_addr_t rd;
	case (op)
		OP_NOP:                       rd = '0;
		OP_LUI:                       rd = instr[20:16];  // rt
		OP_JAL, OP_BLTZAL, OP_BGEZAL: rd = LINK_REG;
		default:                      rd = instr[15:11];  // rd field of SPECIAL and SPECIAL2
	endcase
	return rd;
endfunction

always_comb begin
	for (int i = 0; i < LANES; i++) begin
		op_next[i] = decode_op(issue_instr[i]);
		rd_next[i] = decode_rd(issue_instr[i], op_next[i]);
	end
end

// Bundle valid is dropped on flush
always_ff @(posedge clk) begin
	if (reset || flush) begin
		dec_valid <= 1'b0;
	end else begin
		dec_valid <= issue_valid;
	end
end

// Slot payload is qualified by dec_valid downstream
always_ff @(posedge clk) begin
	for (int i = 0; i < LANES; i++) begin
		dec_op[i]    <= op_next[i];
		dec_rd[i]    <= rd_next[i];
		dec_instr[i] <= issue_instr[i];
		dec_pc[i]    <= issue_pc[i];
		dec_reg1[i]  <= issue_reg1[i];
		dec_reg2[i]  <= issue_reg2[i];
	end
end

endmodule

// File: sim/exec_checker.sv
`timescale 1ns/1ns

module exec_checker import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      flush,
	input  logic      issue_valid,
	input  uint32_t   issue_instr [LANES],
	input  uint32_t   issue_pc    [LANES],
	input  uint32_t   issue_reg1  [LANES],
	input  uint32_t   issue_reg2  [LANES],
	input  logic      wb_valid    [LANES],
	input  reg_addr_t wb_rd       [LANES],
	input  uint32_t   wb_value    [LANES],
	output int        error_count,
	output int        check_count,
	output int        pending
);

// MIPS32 opcode, function and rt encodings
localparam logic [5:0] MAJ_SPECIAL  = 6'h00;
localparam logic [5:0] MAJ_REGIMM   = 6'h01;
localparam logic [5:0] MAJ_JAL      = 6'h03;
localparam logic [5:0] MAJ_LUI      = 6'h0f;
localparam logic [5:0] MAJ_SPECIAL2 = 6'h1c;
localparam logic [5:0] F_SLL  = 6'h00;
localparam logic [5:0] F_SRL  = 6'h02;
localparam logic [5:0] F_SRA  = 6'h03;
localparam logic [5:0] F_SLLV = 6'h04;
localparam logic [5:0] F_SRLV = 6'h06;
localparam logic [5:0] F_SRAV = 6'h07;
localparam logic [5:0] F_JALR = 6'h09;
localparam logic [5:0] F_MOVZ = 6'h0a;
localparam logic [5:0] F_MOVN = 6'h0b;
localparam logic [5:0] F_ADD  = 6'h20;
localparam logic [5:0] F_ADDU = 6'h21;
localparam logic [5:0] F_SUB  = 6'h22;
localparam logic [5:0] F_SUBU = 6'h23;
localparam logic [5:0] F_AND  = 6'h24;
localparam logic [5:0] F_OR   = 6'h25;
localparam logic [5:0] F_XOR  = 6'h26;
localparam logic [5:0] F_NOR  = 6'h27;
localparam logic [5:0] F_SLT  = 6'h2a;
localparam logic [5:0] F_SLTU = 6'h2b;
localparam logic [5:0] F_CLZ  = 6'h20;  // SPECIAL2
localparam logic [5:0] F_CLO  = 6'h21;  // SPECIAL2
localparam logic [4:0] RT_LTZAL = 5'h10;
localparam logic [4:0] RT_GEZAL = 5'h11;

typedef struct packed {
	int unsigned            tag;    // Cycle in which the bundle was issued
	logic [LANES-1:0][4:0]  rd;
	logic [LANES-1:0][31:0] value;
} exp_bundle_t;

exp_bundle_t exp_q [$];
exp_bundle_t head;
exp_bundle_t fresh;
int unsigned cycle = 0;
int errors = 0;
int checks = 0;
logic any_valid;
reg_addr_t ref_rd;
uint32_t ref_val;

// Number of leading bits equal to b
function automatic uint32_t lead_count(input uint32_t w, input logic b);
	uint32_t n;
	logic run;
	n = 0;
	run = 1'b1;
	for (int i = 31; i >= 0; i--) begin
		run = run && (w[i] == b);
		if (run)
			n++;
	end
	return n;
endfunction

function automatic void exec_ref(input uint32_t instr, pc, r1, r2,
		output reg_addr_t rd, output uint32_t value);
	logic [4:0] sa;
	sa = instr[10:6];
	rd = '0;
	value = '0;
	case (instr[31:26])
		MAJ_LUI: begin
			rd = instr[20:16];
			value = {instr[15:0], 16'h0000};
		end
		MAJ_JAL: begin
			rd = 5'd31;
			value = pc + 32'd8;
		end
		MAJ_REGIMM: if (instr[20:16] == RT_LTZAL || instr[20:16] == RT_GEZAL) begin
			rd = 5'd31;
			value = pc + 32'd8;
		end
		MAJ_SPECIAL2: if (instr[5:0] == F_CLZ || instr[5:0] == F_CLO) begin
			rd = instr[15:11];
			value = lead_count(r1, instr[5:0] == F_CLO);
		end
		MAJ_SPECIAL: begin
			rd = instr[15:11];
			case (instr[5:0])
				F_SLL:  value = r2 << sa;
				F_SRL:  value = r2 >> sa;
				F_SRA:  value = $signed(r2) >>> sa;
				F_SLLV: value = r2 << r1[4:0];
				F_SRLV: value = r2 >> r1[4:0];
				F_SRAV: value = $signed(r2) >>> r1[4:0];
				F_JALR: value = pc + 32'd8;
				F_MOVZ: begin
					value = r1;
					if (r2 != 32'd0)
						rd = '0;
				end
				F_MOVN: begin
					value = r1;
					if (r2 == 32'd0)
						rd = '0;
				end
				F_ADD, F_ADDU: value = r1 + r2;  // No overflow trap
				F_SUB, F_SUBU: value = r1 - r2;
				F_AND:  value = r1 & r2;
				F_OR:   value = r1 | r2;
				F_XOR:  value = r1 ^ r2;
				F_NOR:  value = ~(r1 | r2);
				F_SLT:  value = {31'd0, $signed(r1) < $signed(r2)};
				F_SLTU: value = {31'd0, r1 < r2};
				default: rd = '0;
			endcase
		end
		default: ;
	endcase
endfunction

// Outputs seen at an edge belong to the bundle issued two edges before
task automatic compare_outputs();
	any_valid = 1'b0;
	for (int i = 0; i < LANES; i++) begin
		if (wb_valid[i] !== 1'b0)
			any_valid = 1'b1;
	end
	if (exp_q.size() != 0 && exp_q[0].tag + 32'd2 == cycle) begin
		head = exp_q.pop_front();
		for (int i = 0; i < LANES; i++) begin
			if (wb_valid[i] !== 1'b1) begin
				errors++;
				$display("Error at %0t ns: lane %0d did not retire the bundle of cycle %0d",
					$time, i, head.tag);
			end else begin
				checks++;
				if (wb_rd[i] !== head.rd[i] || wb_value[i] !== head.value[i]) begin
					errors++;
					$display("Fail at %0t ns: lane %0d expected rd %0d value %h, got rd %0d value %h",
						$time, i, head.rd[i], head.value[i], wb_rd[i], wb_value[i]);
				end
			end
		end
	end else if (any_valid) begin
		errors++;
		$display("Error at %0t ns: write-back valid with no bundle expected", $time);
	end
endtask

always @(posedge clk) begin
	cycle = cycle + 1;
	if (reset) begin
		exp_q.delete();
	end else begin
		compare_outputs();
		if (flush) begin
			exp_q.delete();  // Bundle in decode and the one issued now are dropped
		end else if (issue_valid) begin
			fresh.tag = cycle;
			for (int i = 0; i < LANES; i++) begin
				exec_ref(issue_instr[i], issue_pc[i], issue_reg1[i], issue_reg2[i],
					ref_rd, ref_val);
				fresh.rd[i] = ref_rd;
				fresh.value[i] = ref_val;
			end
			exp_q.push_back(fresh);
		end
	end
	pending <= exp_q.size();
	error_count <= errors;
	check_count <= checks;
end

endmodule

// File: sim/tb_exec_cluster.sv
`timescale 1ns/1ns

module tb_exec_cluster import cpu_pkg::*; ();

localparam uint32_t PC0 = 32'h0040_1000;
localparam int RANDOM_BUNDLES = 400;
localparam int DRAIN_LIMIT = 20;  // Cycles allowed for the pipeline to empty
localparam logic [5:0] SPECIAL_FNS [19] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV,
	FN_SRAV, FN_JALR, FN_MOVZ, FN_MOVN, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
	FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};

logic      clk;
logic      reset;
logic      flush;
logic      issue_valid;
uint32_t   issue_instr [LANES];
uint32_t   issue_pc    [LANES];
uint32_t   issue_reg1  [LANES];
uint32_t   issue_reg2  [LANES];
logic      wb_valid    [LANES];
reg_addr_t wb_rd       [LANES];
uint32_t   wb_value    [LANES];
int        error_count;
int        check_count;
int        pending;
int        tb_errors = 0;
integer    seed = 32'h52d7_f55a;

exec_cluster u_exec_cluster (
	.clk         (clk),
	.reset       (reset),
	.flush       (flush),
	.issue_valid (issue_valid),
	.issue_instr (issue_instr),
	.issue_pc    (issue_pc),
	.issue_reg1  (issue_reg1),
	.issue_reg2  (issue_reg2),
	.wb_valid    (wb_valid),
	.wb_rd       (wb_rd),
	.wb_value    (wb_value)
);

exec_checker u_checker (.*);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

function automatic uint32_t r_type(input logic [5:0] fn, input reg_addr_t rd, input shamt_t sa);
	return {OPC_SPECIAL, 10'd0, rd, sa, fn};
endfunction

function automatic uint32_t special2_type(input logic [5:0] fn, input reg_addr_t rd);
	return {OPC_SPECIAL2, 10'd0, rd, 5'd0, fn};
endfunction

function automatic uint32_t i_type(input logic [5:0] opc, input reg_addr_t rt,
		input logic [15:0] imm);
	return {opc, 5'd0, rt, imm};
endfunction

// Random fields under a supported or unknown opcode
function automatic uint32_t random_instr();
	uint32_t w;
	w = $random(seed);
	case ($unsigned($random(seed)) % 8)
		0, 1, 2, 3: begin
			w[31:26] = OPC_SPECIAL;
			w[5:0] = SPECIAL_FNS[$unsigned($random(seed)) % 19];
		end
		4: begin
			w[31:26] = OPC_SPECIAL2;
			w[5:0] = ($random(seed) & 1) ? FN_CLO : FN_CLZ;
		end
		5: begin
			w[31:26] = OPC_REGIMM;
			w[20:16] = ($random(seed) & 1) ? RT_BGEZAL : RT_BLTZAL;
		end
		6: w[31:26] = ($random(seed) & 1) ? OPC_LUI : OPC_JAL;
		default: ;  // Unknown word
	endcase
	return w;
endfunction

task automatic send(input logic with_flush, input uint32_t instr0, pc0, a0, b0,
		input uint32_t instr1, pc1, a1, b1);
	@(posedge clk);
	issue_valid <= 1'b1;
	flush <= with_flush;
	issue_instr[0] <= instr0;
	issue_pc[0] <= pc0;
	issue_reg1[0] <= a0;
	issue_reg2[0] <= b0;
	issue_instr[1] <= instr1;
	issue_pc[1] <= pc1;
	issue_reg1[1] <= a1;
	issue_reg2[1] <= b1;
endtask

task automatic idle(input int cycles);
	repeat (cycles) begin
		@(posedge clk);
		issue_valid <= 1'b0;
		flush <= 1'b0;
	end
endtask

task automatic drain();
	int n;
	n = 0;
	idle(2);
	while (pending != 0 && n < DRAIN_LIMIT) begin
		@(posedge clk);
		n++;
	end
	if (pending != 0) begin
		tb_errors++;
		$display("Timeout at %0t ns: bundles still waiting for write-back", $time);
	end
	idle(2);
endtask

initial begin
	reset = 1'b1;
	flush = 1'b0;
	issue_valid = 1'b0;
	for (int i = 0; i < LANES; i++) begin
		issue_instr[i] = '0;
		issue_pc[i] = '0;
		issue_reg1[i] = '0;
		issue_reg2[i] = '0;
	end
	repeat (8) @(posedge clk);
	reset <= 1'b0;
	idle(6);  // wb_valid must stay low here

	// Logic, add, sub, LUI and compares
	send(1'b0, r_type(FN_AND, 5'd3, 5'd0), PC0, 32'hf0f0_1234, 32'h0ff0_ff00,
		r_type(FN_OR, 5'd4, 5'd0), PC0 + 32'd4, 32'hf0f0_1234, 32'h0ff0_ff00);
	send(1'b0, r_type(FN_XOR, 5'd5, 5'd0), PC0, 32'hf0f0_1234, 32'h0ff0_ff00,
		r_type(FN_NOR, 5'd6, 5'd0), PC0 + 32'd4, 32'hf0f0_1234, 32'h0ff0_ff00);
	send(1'b0, r_type(FN_ADD, 5'd7, 5'd0), PC0, 32'h7fff_ffff, 32'd1,
		r_type(FN_ADDU, 5'd8, 5'd0), PC0 + 32'd4, 32'hffff_ffff, 32'd2);
	send(1'b0, r_type(FN_SUB, 5'd9, 5'd0), PC0, 32'd5, 32'd7,
		r_type(FN_SUBU, 5'd10, 5'd0), PC0 + 32'd4, 32'd0, 32'd1);
	send(1'b0, i_type(OPC_LUI, 5'd11, 16'hbeef), PC0, 32'd0, 32'd0,
		r_type(FN_SLT, 5'd12, 5'd0), PC0 + 32'd4, 32'hffff_ffff, 32'd1);
	send(1'b0, r_type(FN_SLT, 5'd13, 5'd0), PC0, 32'd1, 32'hffff_ffff,
		r_type(FN_SLTU, 5'd14, 5'd0), PC0 + 32'd4, 32'hffff_ffff, 32'd1);
	send(1'b0, r_type(FN_SLTU, 5'd15, 5'd0), PC0, 32'd1, 32'hffff_ffff,
		r_type(FN_SLT, 5'd16, 5'd0), PC0 + 32'd4, 32'h8000_0000, 32'h7fff_ffff);

	// Shifts and bit counts
	send(1'b0, r_type(FN_SLL, 5'd17, 5'd0), PC0, 32'd0, 32'h1234_5678,
		r_type(FN_SRA, 5'd18, 5'd4), PC0 + 32'd4, 32'd0, 32'h8000_00f0);
	send(1'b0, r_type(FN_SRL, 5'd19, 5'd31), PC0, 32'd0, 32'hffff_ffff,
		r_type(FN_SLLV, 5'd20, 5'd0), PC0 + 32'd4, 32'hffff_ffe3, 32'd1);
	send(1'b0, r_type(FN_SRAV, 5'd21, 5'd0), PC0, 32'h0000_0020, 32'h8765_4321,
		r_type(FN_SRLV, 5'd22, 5'd0), PC0 + 32'd4, 32'h0000_0044, 32'hf000_0000);
	send(1'b0, special2_type(FN_CLZ, 5'd23), PC0, 32'd0, 32'd0,
		special2_type(FN_CLZ, 5'd24), PC0 + 32'd4, 32'd1, 32'd0);
	send(1'b0, special2_type(FN_CLO, 5'd25), PC0, 32'hffff_ffff, 32'd0,
		special2_type(FN_CLO, 5'd26), PC0 + 32'd4, 32'hf000_0000, 32'd0);

	// Conditional moves and links
	send(1'b0, r_type(FN_MOVZ, 5'd27, 5'd0), PC0, 32'hcafe_0001, 32'd0,
		r_type(FN_MOVZ, 5'd28, 5'd0), PC0 + 32'd4, 32'hcafe_0002, 32'd5);
	send(1'b0, r_type(FN_MOVN, 5'd29, 5'd0), PC0, 32'hcafe_0003, 32'd0,
		r_type(FN_MOVN, 5'd30, 5'd0), PC0 + 32'd4, 32'hcafe_0004, 32'd9);
	send(1'b0, i_type(OPC_JAL, 5'd0, 16'h0400), PC0 + 32'h40, 32'd0, 32'd0,
		r_type(FN_JALR, 5'd7, 5'd0), PC0 + 32'h44, 32'h0040_2000, 32'd0);
	send(1'b0, i_type(OPC_REGIMM, RT_BLTZAL, 16'hfff0), PC0 + 32'h80, 32'hffff_fff0, 32'd0,
		i_type(OPC_REGIMM, RT_BGEZAL, 16'h0010), PC0 + 32'h84, 32'd3, 32'd0);
	drain();

	// Flush edge drops the bundle in decode and the one issued with it
	send(1'b0, r_type(FN_ADDU, 5'd1, 5'd0), PC0, 32'd1, 32'd2,
		r_type(FN_OR, 5'd2, 5'd0), PC0 + 32'd4, 32'd3, 32'd4);
	send(1'b0, r_type(FN_SUBU, 5'd3, 5'd0), PC0, 32'd9, 32'd4,
		r_type(FN_XOR, 5'd4, 5'd0), PC0 + 32'd4, 32'd5, 32'd6);
	send(1'b1, r_type(FN_AND, 5'd5, 5'd0), PC0, 32'd7, 32'd3,
		r_type(FN_NOR, 5'd6, 5'd0), PC0 + 32'd4, 32'd0, 32'd0);
	send(1'b0, r_type(FN_ADDU, 5'd8, 5'd0), PC0, 32'd10, 32'd20,
		r_type(FN_SLT, 5'd9, 5'd0), PC0 + 32'd4, 32'hffff_fffe, 32'd0);
	drain();

	for (int k = 0; k < RANDOM_BUNDLES; k++) begin
		@(posedge clk);
		issue_valid <= 1'b1;
		flush <= 1'b0;
		for (int i = 0; i < LANES; i++) begin
			issue_instr[i] <= random_instr();
			issue_pc[i] <= $random(seed) & 32'hffff_fffc;
			issue_reg1[i] <= $random(seed);
			issue_reg2[i] <= ($random(seed) % 4 == 0) ? 32'd0 : $random(seed);  // Hits MOVZ/MOVN
		end
	end
	drain();

	$display("Checked %0d lane results, %0d checker errors, %0d testbench errors",
		check_count, error_count, tb_errors);
	if (error_count == 0 && tb_errors == 0 && check_count > 0) begin
		$display("Verification passed");
	end else begin
		$display("Verification failed");
	end
	$finish;
end

endmodule

// File: sources.f
logic/cpu_pkg.sv
logic/count_lead_zero.sv
logic/instr_exec.sv
logic/issue_decode.sv
logic/exec_retire.sv
logic/exec_cluster.sv
sim/exec_checker.sv
sim/tb_exec_cluster.sv
